// ==== source/isa_pkg.sv ====
// RV32I plus optional M encodings only; compressed, atomic and vector encodings are not decoded
package isa_pkg;

    // Data path and field widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    ////////////////////////////////////////////////////////////
    // Major opcodes, instruction bits 6 to 2
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    ////////////////////////////////////////////////////////////
    // Operations handed to execute
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        // Bubble and undecodable word
        NOP = 6'd0,
        INVALID,
        // Upper immediates and jumps
        LUI, AUIPC, JAL, JALR,
        // Conditional branches
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // Loads and stores
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        // Integer arithmetic and logic
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND,
        // Multiply and divide group
        MUL, MULH, MULHSU, MULHU,
        DIV, DIVU, REM, REMU,
        // Privileged and environment
        ECALL, EBREAK, MRET, WFI,
        // CSR access
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI
    } op_e;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

endpackage

// ==== source/pipe_pkg.sv ====
// Bundle layouts assume isa_pkg widths of 32-bit data and 5-bit register addresses
package pipe_pkg;

    // Fetched word with its address and fetch fault
    typedef struct packed {
        logic [isa_pkg::xlen-1:0] instr;
        logic [isa_pkg::xlen-1:0] pc;
        logic                     access_fault;
    } fetch_t;

    // Register file read addresses
    typedef struct packed {
        logic [isa_pkg::reg_addr_w-1:0] rs1;
        logic [isa_pkg::reg_addr_w-1:0] rs2;
    } rf_addr_t;

    // Register file read data, same cycle as the addresses
    typedef struct packed {
        logic [isa_pkg::xlen-1:0] rs1;
        logic [isa_pkg::xlen-1:0] rs2;
    } rf_data_t;

    // Forwarding from execute and retire
    typedef struct packed {
        logic                           exec_we;
        logic [isa_pkg::xlen-1:0]       exec_result;
        logic                           retire_we;
        logic [isa_pkg::reg_addr_w-1:0] retire_rd;
        logic [isa_pkg::xlen-1:0]       retire_data;
    } fwd_t;

    typedef struct packed {
        logic illegal;
        logic misaligned;
        logic access_fault;
    } exc_t;

    // Registered toward execute
    typedef struct packed {
        isa_pkg::op_e                   op;
        logic [isa_pkg::xlen-1:0]       pc;
        logic [isa_pkg::reg_addr_w-1:0] rd;
        logic [isa_pkg::xlen-1:0]       rs1_data;
        logic [isa_pkg::xlen-1:0]       rs2_data;
        logic [isa_pkg::xlen-1:0]       second_op;
        logic [isa_pkg::xlen-1:0]       jump_target;
        logic [isa_pkg::csr_addr_w-1:0] csr_addr;
        exc_t                           exc;
        logic                           killed;
    } exec_bundle_t;

endpackage

// ==== source/op_decoder.sv ====
// Purely combinational; FENCE decodes as NOP, and with en_mul at 0 the M group is INVALID
module op_decoder #(
    parameter bit en_mul = 1'b1
) (
    input  logic [isa_pkg::xlen-1:0] instr_i,
    output isa_pkg::op_e             op_o,
    output isa_pkg::format_e         format_o
);
    import isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instr_i[6:2]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////////////////////////
    // Operation
    ////////////////////////////////////////////////////////////

    always_comb begin
        op_o = INVALID;
        case (opcode)
            OPC_LUI:   op_o = LUI;
            OPC_AUIPC: op_o = AUIPC;
            OPC_JAL:   op_o = JAL;
            OPC_JALR:  op_o = (funct3 == 3'b000) ? JALR : INVALID;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op_o = BEQ;
                    3'b001:  op_o = BNE;
                    3'b100:  op_o = BLT;
                    3'b101:  op_o = BGE;
                    3'b110:  op_o = BLTU;
                    3'b111:  op_o = BGEU;
                    default: op_o = INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  op_o = LB;
                    3'b001:  op_o = LH;
                    3'b010:  op_o = LW;
                    3'b100:  op_o = LBU;
                    3'b101:  op_o = LHU;
                    default: op_o = INVALID;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  op_o = SB;
                    3'b001:  op_o = SH;
                    3'b010:  op_o = SW;
                    default: op_o = INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                // Shift immediates still constrain funct7
                case ({funct7, funct3}) inside
                    10'b???????000: op_o = ADD;
                    10'b0000000001: op_o = SLL;
                    10'b???????010: op_o = SLT;
                    10'b???????011: op_o = SLTU;
                    10'b???????100: op_o = XOR;
                    10'b0000000101: op_o = SRL;
                    10'b0100000101: op_o = SRA;
                    10'b???????110: op_o = OR;
                    10'b???????111: op_o = AND;
                    default:        op_o = INVALID;
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000000: op_o = ADD;
                    10'b0100000000: op_o = SUB;
                    10'b0000000001: op_o = SLL;
                    10'b0000000010: op_o = SLT;
                    10'b0000000011: op_o = SLTU;
                    10'b0000000100: op_o = XOR;
                    10'b0000000101: op_o = SRL;
                    10'b0100000101: op_o = SRA;
                    10'b0000000110: op_o = OR;
                    10'b0000000111: op_o = AND;
                    10'b0000001000: op_o = en_mul ? MUL    : INVALID;
                    10'b0000001001: op_o = en_mul ? MULH   : INVALID;
                    10'b0000001010: op_o = en_mul ? MULHSU : INVALID;
                    10'b0000001011: op_o = en_mul ? MULHU  : INVALID;
                    10'b0000001100: op_o = en_mul ? DIV    : INVALID;
                    10'b0000001101: op_o = en_mul ? DIVU   : INVALID;
                    10'b0000001110: op_o = en_mul ? REM    : INVALID;
                    10'b0000001111: op_o = en_mul ? REMU   : INVALID;
                    default:        op_o = INVALID;
                endcase
            end
            OPC_MISC_MEM: op_o = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM: begin
                // Environment calls need every other field zero
                case (instr_i[31:7]) inside
                    25'b0000000000000000000000000: op_o = ECALL;
                    25'b0000000000010000000000000: op_o = EBREAK;
                    25'b0011000000100000000000000: op_o = MRET;
                    25'b0001000001010000000000000: op_o = WFI;
                    25'b?????????????????001?????: op_o = CSRRW;
                    25'b?????????????????010?????: op_o = CSRRS;
                    25'b?????????????????011?????: op_o = CSRRC;
                    25'b?????????????????101?????: op_o = CSRRWI;
                    25'b?????????????????110?????: op_o = CSRRSI;
                    25'b?????????????????111?????: op_o = CSRRCI;
                    default:                       op_o = INVALID;
                endcase
            end
            default: op_o = INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Format by major opcode
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: format_o = I_TYPE;
            OPC_STORE:                      format_o = S_TYPE;
            OPC_BRANCH:                     format_o = B_TYPE;
            OPC_LUI, OPC_AUIPC:             format_o = U_TYPE;
            OPC_JAL:                        format_o = J_TYPE;
            default:                        format_o = R_TYPE;
        endcase
    end

endmodule

// ==== source/imm_gen.sv ====
// Sign extension always comes from bit 31; R format yields a zero immediate
module imm_gen (
    input  logic [isa_pkg::xlen-1:0] instr_i,
    input  isa_pkg::format_e         format_i,
    output logic [isa_pkg::xlen-1:0] imm_o
);
    import isa_pkg::*;

    logic             sign;
    logic [xlen-1:0]  imm_i;
    logic [xlen-1:0]  imm_s;
    logic [xlen-1:0]  imm_b;
    logic [xlen-1:0]  imm_u;
    logic [xlen-1:0]  imm_j;

    assign sign = instr_i[31];

    assign imm_i = {{21{sign}}, instr_i[30:20]};
    assign imm_s = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
    // Branch and jump offsets are in halfwords
    assign imm_b = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        case (format_i)
            I_TYPE:  imm_o = imm_i;
            S_TYPE:  imm_o = imm_s;
            B_TYPE:  imm_o = imm_b;
            U_TYPE:  imm_o = imm_u;
            J_TYPE:  imm_o = imm_j;
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== source/operand_forward.sv ====
// No x0 guard here; the execute and retire stages must not assert write enable for x0
module operand_forward (
    input  pipe_pkg::rf_addr_t             rf_addr_i,
    input  pipe_pkg::rf_data_t             rf_data_i,
    input  pipe_pkg::fwd_t                 fwd_i,
    input  logic [isa_pkg::reg_addr_w-1:0] exec_rd_i,
    output logic [isa_pkg::xlen-1:0]       rs1_data_o,
    output logic [isa_pkg::xlen-1:0]       rs2_data_o
);
    import isa_pkg::*;

    // Execute result wins over retire data, retire over the register file
    function automatic logic [xlen-1:0] pick(
        input logic [reg_addr_w-1:0] src,
        input logic [xlen-1:0]       rf_data
    );
        logic [xlen-1:0] result;
        if (fwd_i.exec_we && (src == exec_rd_i)) begin
            result = fwd_i.exec_result;
        end else if (fwd_i.retire_we && (src == fwd_i.retire_rd)) begin
            result = fwd_i.retire_data;
        end else begin
            result = rf_data;
        end
        return result;
    endfunction

    always_comb begin
        rs1_data_o = pick(rf_addr_i.rs1, rf_data_i.rs1);
        rs2_data_o = pick(rf_addr_i.rs2, rf_data_i.rs2);
    end

endmodule

// ==== source/hazard_unit.sv ====
// Tracks only the instruction now in execute; a store followed by any load stalls one cycle
module hazard_unit (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     enable_i,
    input  logic [isa_pkg::xlen-1:0] instr_i,
    input  isa_pkg::format_e         format_i,
    input  logic                     exception_i,
    input  logic                     flush_i,
    output logic                     hazard_o,
    output logic                     killed_o
);
    import isa_pkg::*;

    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] locked_rd;
    logic                  locked_store;
    logic                  is_load;
    logic                  is_store;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  hit_rs1;
    logic                  hit_rs2;

    assign rs1      = instr_i[19:15];
    assign rs2      = instr_i[24:20];
    assign rd       = instr_i[11:7];
    assign is_load  = (instr_i[6:2] == OPC_LOAD);
    assign is_store = (instr_i[6:2] == OPC_STORE);

    // Source usage follows the format only
    always_comb begin
        case (format_i)
            R_TYPE, S_TYPE, B_TYPE: {use_rs1, use_rs2} = 2'b11;
            I_TYPE:                 {use_rs1, use_rs2} = 2'b10;
            default:                {use_rs1, use_rs2} = 2'b00;
        endcase
    end

    assign hit_rs1 = use_rs1 && (locked_rd != '0) && (locked_rd == rs1);
    assign hit_rs2 = use_rs2 && (locked_rd != '0) && (locked_rd == rs2);

    assign killed_o = flush_i;
    assign hazard_o = (hit_rs1 || hit_rs2 || (locked_store && is_load))
                      && !flush_i && !exception_i;

    ////////////////////////////////////////////////////////////
    // Lock record, advances with the pipeline register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_rd    <= '0;
            locked_store <= 1'b0;
        end else if (enable_i) begin
            if (hazard_o || flush_i) begin
                // A bubble goes to execute and holds no register
                locked_rd    <= '0;
                locked_store <= 1'b0;
            end else begin
                locked_rd    <= is_load ? rd : '0;
                locked_store <= is_store;
            end
        end
    end

endmodule

// ==== source/decode_stage.sv ====
// Aligned 32-bit fetch only; rf_data_i must return in the same cycle as rf_addr_o
module decode_stage #(
    parameter bit en_mul = 1'b1
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   flush_i,
    input  pipe_pkg::fetch_t       fetch_i,
    output pipe_pkg::rf_addr_t     rf_addr_o,
    input  pipe_pkg::rf_data_t     rf_data_i,
    input  pipe_pkg::fwd_t         fwd_i,
    output pipe_pkg::exec_bundle_t exec_o,
    output logic                   hazard_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    op_e          op;
    format_e      fmt;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] second_op;
    logic         killed;
    logic         exception;
    exc_t         exc;
    exec_bundle_t exec_d;

    assign rf_addr_o.rs1 = fetch_i.instr[19:15];
    assign rf_addr_o.rs2 = fetch_i.instr[24:20];

    op_decoder #(
        .en_mul   (en_mul)
    ) u_op_decoder (
        .instr_i  (fetch_i.instr),
        .op_o     (op),
        .format_o (fmt)
    );

    imm_gen u_imm_gen (
        .instr_i  (fetch_i.instr),
        .format_i (fmt),
        .imm_o    (imm)
    );

    // Execute forwarding is keyed on the rd now held in execute
    operand_forward u_operand_forward (
        .rf_addr_i  (rf_addr_o),
        .rf_data_i  (rf_data_i),
        .fwd_i      (fwd_i),
        .exec_rd_i  (exec_o.rd),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    hazard_unit u_hazard_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable_i),
        .instr_i     (fetch_i.instr),
        .format_i    (fmt),
        .exception_i (exception),
        .flush_i     (flush_i),
        .hazard_o    (hazard_o),
        .killed_o    (killed)
    );

    ////////////////////////////////////////////////////////////
    // Exception flags, all dropped for a killed instruction
    ////////////////////////////////////////////////////////////

    assign exc.illegal      = ((fetch_i.instr[1:0] != 2'b11) || (op == INVALID)) && !killed;
    assign exc.misaligned   = (fetch_i.pc[1:0] != 2'b00) && !killed;
    assign exc.access_fault = fetch_i.access_fault && !killed;
    assign exception        = exc.illegal || exc.misaligned || exc.access_fault;

    // Immediate replaces rs2 for I, S and U
    always_comb begin
        case (fmt)
            I_TYPE, S_TYPE, U_TYPE: second_op = imm;
            default:                second_op = rs2_data;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Pipeline register toward execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        exec_d.op          = (hazard_o || killed) ? NOP : op;
        exec_d.pc          = fetch_i.pc;
        exec_d.rd          = fetch_i.instr[11:7];
        exec_d.rs1_data    = rs1_data;
        exec_d.rs2_data    = rs2_data;
        exec_d.second_op   = second_op;
        exec_d.jump_target = fetch_i.pc + imm;
        exec_d.csr_addr    = fetch_i.instr[31:20];
        exec_d.exc         = exc;
        exec_d.killed      = killed;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            exec_o    <= '0;
            exec_o.op <= NOP;
        end else if (enable_i) begin
            exec_o <= exec_d;
        end
    end

endmodule

// ==== verif/decode_stage_chk.sv ====
// Bound to every decode_stage; all properties sample on the rising clock edge
module decode_stage_chk (
    input logic                   clk,
    input logic                   reset_n,
    input logic                   enable_i,
    input logic                   flush_i,
    input logic                   hazard_o,
    input pipe_pkg::exec_bundle_t exec_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;

    // First edge out of reset still sees the reset bundle
    a_reset_nop: assert property (@(posedge clk) $rose(reset_n) |-> exec_o.op == NOP)
        else $error("exec_o.op is not NOP right after reset");

    a_flush_no_hazard: assert property (
        @(posedge clk) disable iff (!reset_n) flush_i |-> !hazard_o)
        else $error("hazard_o high while flush_i is high");

    // A stall request turns into a bubble
    a_hazard_bubble: assert property (
        @(posedge clk) disable iff (!reset_n) (hazard_o && enable_i) |=> exec_o.op == NOP)
        else $error("hazard with enable did not register a NOP");

    a_hold: assert property (
        @(posedge clk) disable iff (!reset_n) !enable_i |=> $stable(exec_o))
        else $error("exec_o changed while enable_i was low");

endmodule

bind decode_stage decode_stage_chk u_chk (.*);

// ==== verif/tb_decode_stage.sv ====
// Assumes en_mul at its default of 1; register numbers are kept small so forwarding hits
module tb_decode_stage;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int num_tests       = 5;
    localparam int cycles_per_test = 200;
    localparam int low_w           = $bits(exec_bundle_t) - 6;

    logic         clk;
    logic         reset_n;
    logic         enable;
    logic         flush;
    fetch_t       fetch;
    rf_addr_t     rf_addr;
    rf_data_t     rf_data;
    fwd_t         fwd;
    exec_bundle_t exec_bundle;
    logic         hazard;

    // Reference model state
    exec_bundle_t model_q;
    logic         model_known;
    logic [4:0]   lock_rd;
    logic         lock_store;
    op_e          cur_op;
    logic         cur_known;
    logic         hold;
    logic [15:0]  lfsr;
    int           test_errors;
    int           total_errors;
    int           failed_tests;

    decode_stage u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .enable_i  (enable),
        .flush_i   (flush),
        .fetch_i   (fetch),
        .rf_addr_o (rf_addr),
        .rf_data_i (rf_data),
        .fwd_i     (fwd),
        .exec_o    (exec_bundle),
        .hazard_o  (hazard)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #((num_tests * cycles_per_test + 20) * 100);
        $display("Watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference rules
    ////////////////////////////////////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic format_e exp_format(input logic [31:0] w);
        case (w[6:2])
            5'b11001, 5'b00000, 5'b00100: return I_TYPE;
            5'b01000:                     return S_TYPE;
            5'b11000:                     return B_TYPE;
            5'b01101, 5'b00101:           return U_TYPE;
            5'b11011:                     return J_TYPE;
            default:                      return R_TYPE;
        endcase
    endfunction

    function automatic logic [31:0] exp_imm(input logic [31:0] w, input format_e f);
        case (f)
            I_TYPE:  return {{20{w[31]}}, w[31:20]};
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    // Execute result, then retire data, then register file
    function automatic logic [31:0] forward_model(input logic [4:0] src, input logic [31:0] rf);
        if (fwd.exec_we && src == model_q.rd) return fwd.exec_result;
        if (fwd.retire_we && src == fwd.retire_rd) return fwd.retire_data;
        return rf;
    endfunction

    task automatic report(input string test, input string what,
                          input logic [255:0] expv, input logic [255:0] actv);
        $display("FAIL %s %s: expected %0h actual %0h", test, what, expv, actv);
        test_errors++;
    endtask

    task automatic close_test(input string name, input int cycles);
        $display("%-8s %0d cycles, %0d errors", name, cycles, test_errors);
        if (test_errors != 0) failed_tests++;
        total_errors += test_errors;
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic pick_instr(input logic haz_mix);
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] r;
        logic [5:0]  opv;
        int          width;
        kind = 4'(rand_bits(4));
        if (haz_mix && rand_bits(1) != 0) kind = (rand_bits(1) != 0) ? 4'd5 : 4'd7;
        width = haz_mix ? 2 : 3;
        rd    = 5'(rand_bits(width));
        rs1   = 5'(rand_bits(width));
        rs2   = 5'(rand_bits(width));
        r     = rand_bits(32);
        case (kind)
            4'd0:  {fetch.instr, opv} = {r[31:12], rd, 7'b0110111, 6'(LUI)};
            4'd1:  {fetch.instr, opv} = {r[31:12], rd, 7'b0010111, 6'(AUIPC)};
            4'd2:  {fetch.instr, opv} = {r[31:12], rd, 7'b1101111, 6'(JAL)};
            4'd3:  {fetch.instr, opv} = {r[31:20], rs1, 3'b000, rd, 7'b1100111, 6'(JALR)};
            4'd4:  {fetch.instr, opv} = {r[31:25], rs2, rs1, 3'b111, r[11:7], 7'b1100011, 6'(BGEU)};
            4'd5:  {fetch.instr, opv} = {r[31:20], rs1, 3'b010, rd, 7'b0000011, 6'(LW)};
            4'd6:  {fetch.instr, opv} = {r[31:20], rs1, 3'b100, rd, 7'b0000011, 6'(LBU)};
            4'd7:  {fetch.instr, opv} = {r[31:25], rs2, rs1, 3'b010, r[11:7], 7'b0100011, 6'(SW)};
            4'd8:  {fetch.instr, opv} = {r[31:20], rs1, 3'b000, rd, 7'b0010011, 6'(ADD)};
            4'd9:  {fetch.instr, opv} = {7'h20, r[24:20], rs1, 3'b101, rd, 7'b0010011, 6'(SRA)};
            4'd10: {fetch.instr, opv} = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011, 6'(SUB)};
            4'd11: {fetch.instr, opv} = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011, 6'(XOR)};
            4'd12: {fetch.instr, opv} = {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011, 6'(MUL)};
            4'd13: {fetch.instr, opv} = {r[31:20], rs1, 3'b010, rd, 7'b1110011, 6'(CSRRS)};
            4'd14: {fetch.instr, opv} = {7'h7f, rs2, rs1, 3'b000, rd, 7'b0110011, 6'(INVALID)};
            // Random word with a non-32-bit length code
            default: {fetch.instr, opv} = {r[31:2], 2'b00, 6'(NOP)};
        endcase
        cur_op    = op_e'(opv);
        cur_known = (kind != 4'd15);
        fetch.pc  = rand_bits(32) & 32'hFFFF_FFFC;
        if (rand_bits(3) == 0) fetch.pc[1:0] = 2'(rand_bits(2));
        fetch.access_fault = (rand_bits(4) == 0);
    endtask

    task automatic run_test(input string name, input logic fwd_on, input logic flush_on,
                            input logic stall_on, input logic haz_mix);
        format_e     fmt;
        logic [31:0] imm;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        exc_t        exc;
        logic        use1;
        logic        use2;
        logic        haz;
        for (int c = 0; c < cycles_per_test; c++) begin
            if (!hold) pick_instr(haz_mix);
            enable  = stall_on ? (rand_bits(1) != 0) : 1'b1;
            flush   = flush_on ? (rand_bits(2) == 0) : 1'b0;
            rf_data = {rand_bits(32), rand_bits(32)};
            fwd     = '0;
            if (fwd_on) begin
                fwd = {rand_bits(1) != 0, rand_bits(32), rand_bits(1) != 0,
                       5'(rand_bits(3)), rand_bits(32)};
            end
            #25;
            fmt   = exp_format(fetch.instr);
            imm   = exp_imm(fetch.instr, fmt);
            rs1_v = forward_model(fetch.instr[19:15], rf_data.rs1);
            rs2_v = forward_model(fetch.instr[24:20], rf_data.rs2);
            exc.illegal      = (fetch.instr[1:0] != 2'b11 || (cur_known && cur_op == INVALID))
                               && !flush;
            exc.misaligned   = (fetch.pc[1:0] != 2'b00) && !flush;
            exc.access_fault = fetch.access_fault && !flush;
            use1 = (fmt != U_TYPE) && (fmt != J_TYPE);
            use2 = (fmt == R_TYPE) || (fmt == S_TYPE) || (fmt == B_TYPE);
            haz  = ((use1 && lock_rd != 5'd0 && lock_rd == fetch.instr[19:15])
                    || (use2 && lock_rd != 5'd0 && lock_rd == fetch.instr[24:20])
                    || (lock_store && fetch.instr[6:2] == 5'b00000))
                   && !flush && (exc == 3'b000);
            if (hazard !== haz) report(name, "hazard_o", 256'(haz), 256'(hazard));
            if (rf_addr !== {fetch.instr[19:15], fetch.instr[24:20]}) begin
                report(name, "rf_addr_o", 256'({fetch.instr[19:15], fetch.instr[24:20]}),
                       256'(rf_addr));
            end
            if (enable) begin
                model_q.op          = (haz || flush) ? NOP : cur_op;
                model_known         = haz || flush || cur_known;
                model_q.pc          = fetch.pc;
                model_q.rd          = fetch.instr[11:7];
                model_q.rs1_data    = rs1_v;
                model_q.rs2_data    = rs2_v;
                model_q.second_op   = (fmt == I_TYPE || fmt == S_TYPE || fmt == U_TYPE)
                                      ? imm : rs2_v;
                model_q.jump_target = fetch.pc + imm;
                model_q.csr_addr    = fetch.instr[31:20];
                model_q.exc         = exc;
                model_q.killed      = flush;
                lock_rd    = (haz || flush || fetch.instr[6:2] != 5'b00000)
                             ? 5'd0 : fetch.instr[11:7];
                lock_store = !(haz || flush) && fetch.instr[6:2] == 5'b01000;
            end
            hold = haz;
            @(negedge clk);
            if (model_known && exec_bundle.op !== model_q.op) begin
                report(name, "exec_o.op", 256'(model_q.op), 256'(exec_bundle.op));
            end
            if (exec_bundle[low_w-1:0] !== model_q[low_w-1:0]) begin
                report(name, "exec_o", 256'(model_q[low_w-1:0]), 256'(exec_bundle[low_w-1:0]));
            end
        end
        close_test(name, cycles_per_test);
    endtask

    initial begin
        lfsr         = 16'd35845;
        reset_n      = 1'b0;
        enable       = 1'b0;
        flush        = 1'b0;
        fetch        = '0;
        rf_data      = '0;
        fwd          = '0;
        model_q      = '0;
        model_q.op   = NOP;
        model_known  = 1'b1;
        lock_rd      = 5'd0;
        lock_store   = 1'b0;
        cur_op       = NOP;
        cur_known    = 1'b1;
        hold         = 1'b0;
        test_errors  = 0;
        total_errors = 0;
        failed_tests = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        if (exec_bundle.op !== NOP) report("reset", "exec_o.op", 256'(NOP), 256'(exec_bundle.op));
        if ({exec_bundle.exc, exec_bundle.killed} !== 4'b0000) begin
            report("reset", "exc and killed", 256'(0),
                   256'({exec_bundle.exc, exec_bundle.killed}));
        end
        close_test("reset", 0);
        run_test("random", 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("forward", 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("hazard", 1'b1, 1'b0, 1'b0, 1'b1);
        run_test("flush", 1'b1, 1'b1, 1'b0, 1'b1);
        run_test("stall", 1'b1, 1'b1, 1'b1, 1'b1);
        $display("Tests run %0d, failed %0d, errors %0d", num_tests + 1, failed_tests,
                 total_errors);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== decode_stage.f ====
source/isa_pkg.sv
source/pipe_pkg.sv
source/op_decoder.sv
source/imm_gen.sv
source/operand_forward.sv
source/hazard_unit.sv
source/decode_stage.sv
verif/decode_stage_chk.sv
verif/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_decode_stage -f decode_stage.f \
    && ./obj_dir/Vtb_decode_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
